/* cpu_top.f */
hw/cpu_isa_pkg.sv
hw/cpu_ctrl_pkg.sv
hw/cpu_ctrl_if.sv
hw/alu.sv
hw/barrel_shifter.sv
hw/cpu_control.sv
hw/fetch_unit.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/cpu_top.sv
testbench/cpu_checker.sv
testbench/cpu_tb.sv

/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_isa_pkg::*; import cpu_ctrl_pkg::*; (
    input  wire word_t   op_a,
    input  wire word_t   op_b,
    input  wire alu_op_t alu_op,
    output word_t        result,
    output logic         zero
);

    always_comb begin
        case (alu_op)
            ALU_SUB:  result = op_a - op_b;
            ALU_NAND: result = ~(op_a & op_b);
            ALU_OR:   result = op_a | op_b;
            default:  result = op_a + op_b;
        endcase
    end

    assign zero = (result == '0);               // Equal operands on subtract

endmodule

`default_nettype wire

/* hw/barrel_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module barrel_shifter import cpu_isa_pkg::*; (
    input  wire word_t     value,
    input  wire [3:0]      amount,
    input  wire shift_fn_t fn,
    output word_t          result
);

    logic  left;
    logic  fill;
    word_t value_rev;
    word_t s_in;
    word_t s8;
    word_t s4;
    word_t s2;
    word_t s1;
    word_t s1_rev;

    assign left = (fn == SH_LEFT) || (fn == SH_LEFT_ALT);
    assign fill = (fn == SH_ARIGHT) ? value[15] : 1'b0;   // Sign fill for arithmetic

    // Left shift runs as a right shift on reversed bits
    assign value_rev = {<<{value}};
    assign s_in      = left ? value_rev : value;

    assign s8 = amount[3] ? {{8{fill}}, s_in[15:8]} : s_in;
    assign s4 = amount[2] ? {{4{fill}}, s8[15:4]} : s8;
    assign s2 = amount[1] ? {{2{fill}}, s4[15:2]} : s4;
    assign s1 = amount[0] ? {fill, s2[15:1]} : s2;

    assign s1_rev = {<<{s1}};
    assign result = left ? s1_rev : s1;

endmodule

`default_nettype wire

/* hw/cpu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_control import cpu_isa_pkg::*; import cpu_ctrl_pkg::*; (
    input  wire          clk,
    input  wire          rst_ABC,
    input  wire opcode_t opcode,
    cpu_ctrl_if.control  ctrl,
    output logic         fetch,
    output logic         dmem_re,
    output logic         dmem_we
);

    logic [NUM_STATES-1:0] state;
    logic [NUM_STATES-1:0] state_nxt;
    logic [15:0]           op_hot;              // Decoded opcode
    logic                  alu_st;
    logic                  imm_st;

    assign op_hot = 16'(1) << opcode;

    always_ff @(posedge clk or posedge rst_ABC) begin
        if (rst_ABC) begin
            state <= NUM_STATES'(1) << ST_FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = '0;
        // Back to fetch after the last state of each class
        state_nxt[ST_FETCH] = state[ST_WRITE_BACK] | state[ST_BRANCH] | state[ST_JUMP]
                            | state[ST_MEM_WRITE] | state[ST_LOAD_WB];

        state_nxt[ST_DECODE_BR] = state[ST_FETCH] & (op_hot[OP_BEQ] | op_hot[OP_BNE]
                                | op_hot[OP_ADD] | op_hot[OP_NAND] | op_hot[OP_SUB]
                                | op_hot[OP_OR]);
        state_nxt[ST_DECODE_IMM] = state[ST_FETCH] & (op_hot[OP_SHIFT] | op_hot[OP_ORI]
                                 | op_hot[OP_NANDI] | op_hot[OP_ADDI] | op_hot[OP_ADDIU]
                                 | op_hot[OP_SUBI] | op_hot[OP_SUBIU]);
        state_nxt[ST_JUMP]     = state[ST_FETCH] & op_hot[OP_JUMP];
        state_nxt[ST_MEM_BASE] = state[ST_FETCH] & (op_hot[OP_LOAD] | op_hot[OP_STORE]);

        state_nxt[ST_ALU_ADD]  = state[ST_DECODE_BR] & op_hot[OP_ADD];
        state_nxt[ST_ALU_SUB]  = state[ST_DECODE_BR] & op_hot[OP_SUB];
        state_nxt[ST_ALU_NAND] = state[ST_DECODE_BR] & op_hot[OP_NAND];
        state_nxt[ST_ALU_OR]   = state[ST_DECODE_BR] & op_hot[OP_OR];
        state_nxt[ST_BRANCH]   = state[ST_DECODE_BR] & (op_hot[OP_BEQ] | op_hot[OP_BNE]);

        state_nxt[ST_IMM_ADD]  = state[ST_DECODE_IMM] & op_hot[OP_ADDI];
        state_nxt[ST_IMM_ADDU] = state[ST_DECODE_IMM] & op_hot[OP_ADDIU];
        state_nxt[ST_IMM_SUB]  = state[ST_DECODE_IMM] & op_hot[OP_SUBI];
        state_nxt[ST_IMM_SUBU] = state[ST_DECODE_IMM] & op_hot[OP_SUBIU];
        state_nxt[ST_IMM_NAND] = state[ST_DECODE_IMM] & op_hot[OP_NANDI];
        state_nxt[ST_IMM_OR]   = state[ST_DECODE_IMM] & op_hot[OP_ORI];
        state_nxt[ST_SHIFT]    = state[ST_DECODE_IMM] & op_hot[OP_SHIFT];

        state_nxt[ST_WRITE_BACK] = alu_st | imm_st | state[ST_SHIFT];

        state_nxt[ST_MEM_ADDR]  = state[ST_MEM_BASE];
        state_nxt[ST_MEM_READ]  = state[ST_MEM_ADDR] & op_hot[OP_LOAD];
        state_nxt[ST_MEM_WRITE] = state[ST_MEM_ADDR] & op_hot[OP_STORE];
        state_nxt[ST_LOAD_WB]   = state[ST_MEM_READ];
    end

    assign alu_st = state[ST_ALU_ADD] | state[ST_ALU_SUB] | state[ST_ALU_NAND]
                  | state[ST_ALU_OR];
    assign imm_st = state[ST_IMM_ADD] | state[ST_IMM_ADDU] | state[ST_IMM_SUB]
                  | state[ST_IMM_SUBU] | state[ST_IMM_NAND] | state[ST_IMM_OR];

    assign fetch   = state[ST_FETCH];
    assign dmem_re = state[ST_MEM_READ];
    assign dmem_we = state[ST_MEM_WRITE];

    assign ctrl.pc_wr  = state[ST_FETCH] | state[ST_JUMP];
    assign ctrl.pc_src = state[ST_BRANCH];
    assign ctrl.eq_bar = opcode[0];             // Set for bne

    // Bank selects stay on through both address states
    assign ctrl.rn2_data_bank = state[ST_MEM_BASE] | state[ST_MEM_ADDR];
    assign ctrl.read3         = state[ST_DECODE_BR];
    assign ctrl.reg_dst       = state[ST_LOAD_WB];
    assign ctrl.reg_wr        = state[ST_WRITE_BACK] | state[ST_LOAD_WB];
    assign ctrl.shift_sel     = state[ST_SHIFT];
    assign ctrl.mem_to_reg    = state[ST_LOAD_WB];

    assign ctrl.src_a = (alu_st | imm_st | state[ST_BRANCH] | state[ST_MEM_ADDR])
                      ? SRC_A_REG : SRC_A_PC;

    always_comb begin
        if (state[ST_MEM_BASE] | state[ST_MEM_ADDR]) begin
            ctrl.rn1_sel = RN1_BASE_BANK;
        end else if (state[ST_DECODE_IMM]) begin
            ctrl.rn1_sel = RN1_RD;              // Immediates and shifts work on rd
        end else begin
            ctrl.rn1_sel = RN1_RS;
        end
    end

    always_comb begin
        ctrl.src_b = SRC_B_TWO;                 // PC increment by default
        if (alu_st | state[ST_BRANCH]) begin
            ctrl.src_b = SRC_B_REG;
        end else if (state[ST_IMM_ADDU] | state[ST_IMM_SUBU]) begin
            ctrl.src_b = SRC_B_ZEXT;
        end else if (imm_st) begin
            ctrl.src_b = SRC_B_SEXT;
        end else if (state[ST_MEM_ADDR]) begin
            ctrl.src_b = SRC_B_SEXT_X2;
        end else if (state[ST_JUMP]) begin
            ctrl.src_b = SRC_B_OFFSET12;
        end
    end

    always_comb begin
        ctrl.alu_op = ALU_ADD;
        if (state[ST_ALU_SUB] | state[ST_IMM_SUB] | state[ST_IMM_SUBU] | state[ST_BRANCH]) begin
            ctrl.alu_op = ALU_SUB;              // Branch compares by subtraction
        end else if (state[ST_ALU_NAND] | state[ST_IMM_NAND]) begin
            ctrl.alu_op = ALU_NAND;
        end else if (state[ST_ALU_OR] | state[ST_IMM_OR]) begin
            ctrl.alu_op = ALU_OR;
        end
    end

endmodule

`default_nettype wire

/* hw/cpu_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface cpu_ctrl_if import cpu_ctrl_pkg::*; ();

    logic     pc_wr;
    logic     pc_src;                           // Branch target from C
    logic     eq_bar;
    rn1_sel_t rn1_sel;
    logic     rn2_data_bank;
    logic     read3;
    logic     reg_dst;                          // Write to data bank
    logic     reg_wr;
    src_a_t   src_a;
    src_b_t   src_b;
    alu_op_t  alu_op;
    logic     shift_sel;                        // Shifter into alu_out
    logic     mem_to_reg;

    modport control (
        output pc_wr, pc_src, eq_bar,
        output rn1_sel, rn2_data_bank, read3, reg_dst, reg_wr,
        output src_a, src_b, alu_op, shift_sel, mem_to_reg
    );

    modport fetch (input pc_wr, pc_src, eq_bar);

    modport regs (input rn1_sel, rn2_data_bank, read3, reg_dst, reg_wr);

    modport exec (input src_a, src_b, alu_op, shift_sel, mem_to_reg);

endinterface

`default_nettype wire

/* hw/cpu_ctrl_pkg.sv */
`default_nettype none

package cpu_ctrl_pkg;

    // Bit positions of the one-hot state vector
    typedef enum logic [4:0] {
        ST_FETCH      = 5'd0,
        ST_DECODE_BR  = 5'd1,
        ST_ALU_ADD    = 5'd2,
        ST_ALU_SUB    = 5'd3,
        ST_ALU_NAND   = 5'd4,
        ST_ALU_OR     = 5'd5,
        ST_WRITE_BACK = 5'd6,
        ST_DECODE_IMM = 5'd7,
        ST_IMM_ADD    = 5'd8,
        ST_IMM_ADDU   = 5'd9,
        ST_IMM_SUB    = 5'd10,
        ST_IMM_SUBU   = 5'd11,
        ST_IMM_NAND   = 5'd12,
        ST_IMM_OR     = 5'd13,
        ST_BRANCH     = 5'd14,
        ST_JUMP       = 5'd15,
        ST_MEM_BASE   = 5'd16,
        ST_MEM_ADDR   = 5'd17,
        ST_MEM_READ   = 5'd18,
        ST_LOAD_WB    = 5'd19,
        ST_MEM_WRITE  = 5'd20,
        ST_SHIFT      = 5'd21
    } state_idx_t;

    localparam int unsigned NUM_STATES = 22;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_NAND, ALU_OR} alu_op_t;

    typedef enum logic {SRC_A_PC, SRC_A_REG} src_a_t;

    typedef enum logic [2:0] {
        SRC_B_TWO      = 3'd0,                  // Constant instruction step
        SRC_B_REG      = 3'd1,
        SRC_B_SEXT     = 3'd2,                  // Sign-extended ir[7:0]
        SRC_B_ZEXT     = 3'd3,                  // Zero-extended ir[7:0]
        SRC_B_SEXT_X2  = 3'd4,                  // Word offset for load/store
        SRC_B_OFFSET12 = 3'd5                   // Jump offset ir[11:0]
    } src_b_t;

    typedef enum logic [1:0] {RN1_RS, RN1_RD, RN1_BASE_BANK} rn1_sel_t;

endpackage

`default_nettype wire

/* hw/cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

    typedef logic [15:0] word_t;                // Data and address word
    typedef logic [3:0]  reg_idx_t;

    localparam int unsigned NUM_REGS   = 16;
    localparam int unsigned INSTR_STEP = 2;     // Bytes per instruction

    // Load/store register banks with low bits taken from rd
    localparam logic [1:0] BASE_BANK = 2'b10;   // r8 to r11
    localparam logic [1:0] DATA_BANK = 2'b11;   // r12 to r15

    typedef enum logic [3:0] {
        OP_SHIFT = 4'd0,
        OP_LOAD  = 4'd1,
        OP_STORE = 4'd2,
        OP_JUMP  = 4'd3,
        OP_BEQ   = 4'd4,
        OP_BNE   = 4'd5,
        OP_ORI   = 4'd6,
        OP_NANDI = 4'd7,
        OP_ADD   = 4'd8,
        OP_ADDI  = 4'd9,
        OP_ADDIU = 4'd10,
        OP_NAND  = 4'd11,
        OP_SUB   = 4'd12,
        OP_SUBI  = 4'd13,
        OP_SUBIU = 4'd14,
        OP_OR    = 4'd15
    } opcode_t;

    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rd;                           // Dest, branch target, shift source
        reg_idx_t rs;                           // Source 1 or shift amount
        reg_idx_t rt;                           // Source 2 or shift function
    } instr_t;

    typedef enum logic [1:0] {
        SH_LEFT     = 2'b00,
        SH_LEFT_ALT = 2'b01,                    // Also a left shift
        SH_LRIGHT   = 2'b10,
        SH_ARIGHT   = 2'b11
    } shift_fn_t;

endpackage

`default_nettype wire

/* hw/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_isa_pkg::*; (
    input  wire        clk,
    input  wire        rst_ABC,
    output logic       fetch,
    output word_t      imem_addr,
    input  wire word_t imem_data,
    output logic       dmem_re,
    output logic       dmem_we,
    output word_t      dmem_addr,
    output word_t      dmem_wdata,
    input  wire word_t dmem_rdata
);

    cpu_ctrl_if ctrl_bus ();

    word_t   pc;
    word_t   alu_result;
    word_t   alu_out;
    word_t   a;
    word_t   b;
    word_t   c;
    word_t   wd;
    instr_t  ir;
    logic    zero;
    opcode_t dec_opcode;

    // New instruction decodes straight from the bus in the fetch cycle
    assign dec_opcode = fetch ? opcode_t'(imem_data[15:12]) : ir.opcode;

    assign imem_addr  = pc;
    assign dmem_addr  = alu_out;
    assign dmem_wdata = b;                      // Data-bank register

    cpu_control u_control (
        .clk     (clk),
        .rst_ABC (rst_ABC),
        .opcode  (dec_opcode),
        .ctrl    (ctrl_bus.control),
        .fetch   (fetch),
        .dmem_re (dmem_re),
        .dmem_we (dmem_we)
    );

    fetch_unit u_fetch (
        .clk        (clk),
        .rst_ABC    (rst_ABC),
        .ctrl       (ctrl_bus.fetch),
        .alu_result (alu_result),
        .target     (c),
        .zero       (zero),
        .imem_data  (imem_data),
        .pc         (pc),
        .ir         (ir)
    );

    reg_file u_regs (
        .clk     (clk),
        .rst_ABC (rst_ABC),
        .ctrl    (ctrl_bus.regs),
        .ir      (ir),
        .wd      (wd),
        .a       (a),
        .b       (b),
        .c       (c)
    );

    exec_unit u_exec (
        .clk        (clk),
        .rst_ABC    (rst_ABC),
        .ctrl       (ctrl_bus.exec),
        .pc         (pc),
        .a          (a),
        .b          (b),
        .ir         (ir),
        .dmem_rdata (dmem_rdata),
        .alu_result (alu_result),
        .zero       (zero),
        .alu_out    (alu_out),
        .mdr        (),
        .wd         (wd)
    );

endmodule

`default_nettype wire

/* hw/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit import cpu_isa_pkg::*; import cpu_ctrl_pkg::*; (
    input  wire         clk,
    input  wire         rst_ABC,
    cpu_ctrl_if.exec    ctrl,
    input  wire word_t  pc,
    input  wire word_t  a,
    input  wire word_t  b,
    input  wire instr_t ir,
    input  wire word_t  dmem_rdata,
    output word_t       alu_result,
    output logic        zero,
    output word_t       alu_out,
    output word_t       mdr,
    output word_t       wd
);

    word_t op_a;
    word_t op_b;
    word_t imm_sext;
    word_t shift_y;

    assign imm_sext = {{8{ir[7]}}, ir[7:0]};
    assign op_a     = (ctrl.src_a == SRC_A_REG) ? a : pc;

    always_comb begin
        case (ctrl.src_b)
            SRC_B_REG:      op_b = b;
            SRC_B_SEXT:     op_b = imm_sext;
            SRC_B_ZEXT:     op_b = {8'h00, ir[7:0]};
            SRC_B_SEXT_X2:  op_b = {imm_sext[14:0], 1'b0};
            SRC_B_OFFSET12: op_b = {4'h0, ir[11:0]};
            default:        op_b = word_t'(INSTR_STEP);
        endcase
    end

    alu u_alu (
        .op_a   (op_a),
        .op_b   (op_b),
        .alu_op (ctrl.alu_op),
        .result (alu_result),
        .zero   (zero)
    );

    // Shift source rd is read into A during decode
    barrel_shifter u_shifter (
        .value  (a),
        .amount (ir.rs),
        .fn     (shift_fn_t'(ir.rt[1:0])),
        .result (shift_y)
    );

    always_ff @(posedge clk or posedge rst_ABC) begin
        if (rst_ABC) begin
            alu_out <= '0;
        end else begin
            alu_out <= ctrl.shift_sel ? shift_y : alu_result;
        end
    end

    always_ff @(posedge clk) begin
        mdr <= dmem_rdata;                      // Valid after the read strobe cycle
    end

    assign wd = ctrl.mem_to_reg ? mdr : alu_out;

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import cpu_isa_pkg::*; (
    input  wire        clk,
    input  wire        rst_ABC,
    cpu_ctrl_if.fetch  ctrl,
    input  wire word_t alu_result,
    input  wire word_t target,
    input  wire        zero,
    input  wire word_t imem_data,
    output word_t      pc,
    output instr_t     ir
);

    logic  pc_load;
    word_t pc_next;

    // Unconditional write, or taken beq/bne
    assign pc_load = ctrl.pc_wr | (ctrl.pc_src & (zero ^ ctrl.eq_bar));
    assign pc_next = ctrl.pc_src ? target : alu_result;

    always_ff @(posedge clk or posedge rst_ABC) begin
        if (rst_ABC) begin
            pc <= '0;
            ir <= '0;
        end else begin
            if (pc_load) begin
                pc <= pc_next;
            end
            if (ctrl.pc_wr && !ctrl.pc_src) begin
                ir <= instr_t'(imem_data);      // Captured with the PC increment
            end
        end
    end

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import cpu_isa_pkg::*; import cpu_ctrl_pkg::*; (
    input  wire         clk,
    input  wire         rst_ABC,
    cpu_ctrl_if.regs    ctrl,
    input  wire instr_t ir,
    input  wire word_t  wd,
    output word_t       a,
    output word_t       b,
    output word_t       c
);

    word_t    regs [NUM_REGS];
    reg_idx_t rn1;
    reg_idx_t rn2;
    reg_idx_t wr_idx;

    always_comb begin
        case (ctrl.rn1_sel)
            RN1_RD:        rn1 = ir.rd;
            RN1_BASE_BANK: rn1 = {BASE_BANK, ir.rd[1:0]};
            default:       rn1 = ir.rs;
        endcase
    end

    assign rn2    = ctrl.rn2_data_bank ? {DATA_BANK, ir.rd[3:2]} : ir.rt;
    assign wr_idx = ctrl.reg_dst ? {DATA_BANK, ir.rd[3:2]} : ir.rd;

    always_ff @(posedge clk or posedge rst_ABC) begin
        if (rst_ABC) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            a <= '0;
            b <= '0;
            c <= '0;
        end else begin
            a <= regs[rn1];
            b <= regs[rn2];
            if (ctrl.read3) begin
                c <= regs[ir.rd];               // Branch target
            end
            if (ctrl.reg_wr && (wr_idx != '0)) begin
                regs[wr_idx] <= wd;             // r0 stays zero
            end
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the CPU testbench with Verilator, run it and search the log for failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f cpu_top.f --top-module cpu_tb -o cpu_sim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/cpu_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || { echo "Simulation aborted, see sim.log"; exit 1; }
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
echo "Simulation passed" && exit 0

/* testbench/cpu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
    input wire clk,
    input wire rst_ABC,
    input wire fetch,
    input wire dmem_re,
    input wire dmem_we
);

    int unsigned fail_count = 0;                // Read by the testbench at the end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst_ABC)
        !(dmem_re && dmem_we))
        else begin
            fail_count = fail_count + 1;
            $error("dmem_re and dmem_we are high in the same cycle");
        end

    // A data strobe never shares a cycle with instruction fetch
    a_fetch_excl: assert property (@(posedge clk) disable iff (rst_ABC)
        !(fetch && (dmem_re || dmem_we)))
        else begin
            fail_count = fail_count + 1;
            $error("data strobe is high together with fetch");
        end

    a_no_early_we: assert property (@(posedge clk) disable iff (rst_ABC)
        !(dmem_we && $past(fetch)))
        else begin
            fail_count = fail_count + 1;
            $error("dmem_we is high in the cycle right after fetch");
        end

endmodule

`default_nettype wire

/* testbench/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_isa_pkg::*; ();

    localparam int unsigned RAND_SEED = 32'h78fcc1ad;
    localparam int NUM_INSTR          = 3000;
    localparam int FETCH_TIMEOUT      = 12;     // Longest class takes 5 cycles
    localparam int DATA_STROBE_CYCLE  = 3;      // mem_read or mem_write
    localparam int KIND_NONE          = 0;
    localparam int KIND_LOAD          = 1;
    localparam int KIND_STORE         = 2;

    logic  clk;
    logic  rst_ABC;
    logic  fetch;
    logic  dmem_re;
    logic  dmem_we;
    word_t imem_addr;
    word_t imem_data;
    word_t dmem_addr;
    word_t dmem_wdata;
    word_t dmem_rdata;

    word_t model_regs [NUM_REGS];
    word_t model_pc;
    word_t data_mem [word_t];                   // Sparse map filled by stores

    int    exp_gap;
    int    exp_kind;
    word_t exp_addr;
    word_t exp_wdata;

    int error_count;
    int check_count;
    int timeout_count;

    bind cpu_top cpu_checker u_checker (
        .clk     (clk),
        .rst_ABC (rst_ABC),
        .fetch   (fetch),
        .dmem_re (dmem_re),
        .dmem_we (dmem_we)
    );

    cpu_top UUT (
        .clk        (clk),
        .rst_ABC    (rst_ABC),
        .fetch      (fetch),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_re    (dmem_re),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    function automatic word_t sext8(input logic [7:0] imm);
        return {{8{imm[7]}}, imm};
    endfunction

    function automatic word_t shift_ref(input word_t value, input logic [3:0] amount,
                                        input logic [1:0] fn);
        case (fn)
            2'b10:   return value >> amount;
            2'b11:   return word_t'($signed(value) >>> amount);
            default: return value << amount;    // Both left codes
        endcase
    endfunction

    function automatic word_t mem_read(input word_t addr);
        if (data_mem.exists(addr)) begin
            return data_mem[addr];
        end
        return {addr[7:0], addr[15:8]} ^ 16'h3c5a;  // Untouched words
    endfunction

    function automatic instr_t random_instr();
        instr_t      ins;
        int unsigned pick;
        ins  = instr_t'(16'($urandom));
        pick = $urandom_range(99);
        if (pick < 12) begin
            ins.opcode = OP_SHIFT;
        end else if (pick < 24) begin
            ins.opcode = OP_LOAD;
        end else if (pick < 38) begin
            ins.opcode = OP_STORE;
        end else if (pick < 42) begin
            ins.opcode = OP_JUMP;
        end else if (pick < 50) begin
            ins.opcode = ($urandom_range(1) == 0) ? OP_BEQ : OP_BNE;
            if ($urandom_range(1) == 0) begin
                ins.rt = ins.rs;                // Equal operands half the time
            end
        end else begin
            ins.opcode = opcode_t'(4'd6 + 4'($urandom_range(9)));  // ori through or
        end
        return ins;
    endfunction

    // ISA model applied one instruction at a time
    function automatic void apply_model(input instr_t ins);
        word_t rd_val;
        word_t rs_val;
        word_t rt_val;
        word_t imm_s;
        word_t imm_z;
        word_t result;
        logic  wr_en;
        rd_val   = model_regs[ins.rd];
        rs_val   = model_regs[ins.rs];
        rt_val   = model_regs[ins.rt];
        imm_s    = sext8({ins.rs, ins.rt});
        imm_z    = {8'h00, ins.rs, ins.rt};
        result   = '0;
        wr_en    = 1'b1;
        exp_gap  = 4;
        exp_kind = KIND_NONE;
        model_pc = model_pc + word_t'(INSTR_STEP);
        case (ins.opcode)
            OP_SHIFT: result = shift_ref(rd_val, ins.rs, ins.rt[1:0]);
            OP_LOAD, OP_STORE: begin
                wr_en    = 1'b0;
                exp_addr = model_regs[{BASE_BANK, ins.rd[1:0]}] + (imm_s << 1);
                if (ins.opcode == OP_LOAD) begin
                    exp_gap  = 5;
                    exp_kind = KIND_LOAD;
                    model_regs[{DATA_BANK, ins.rd[3:2]}] = mem_read(exp_addr);
                end else begin
                    exp_kind  = KIND_STORE;
                    exp_wdata = model_regs[{DATA_BANK, ins.rd[3:2]}];
                    data_mem[exp_addr] = exp_wdata;
                end
            end
            OP_JUMP: begin
                wr_en    = 1'b0;
                exp_gap  = 2;
                model_pc = model_pc + {4'h0, ins.rd, ins.rs, ins.rt};
            end
            OP_BEQ, OP_BNE: begin
                wr_en   = 1'b0;
                exp_gap = 3;
                if ((rs_val == rt_val) == (ins.opcode == OP_BEQ)) begin
                    model_pc = rd_val;
                end
            end
            OP_ORI:   result = rd_val | imm_s;
            OP_NANDI: result = ~(rd_val & imm_s);
            OP_ADD:   result = rs_val + rt_val;
            OP_ADDI:  result = rd_val + imm_s;
            OP_ADDIU: result = rd_val + imm_z;
            OP_NAND:  result = ~(rs_val & rt_val);
            OP_SUB:   result = rs_val - rt_val;
            OP_SUBI:  result = rd_val - imm_s;
            OP_SUBIU: result = rd_val - imm_z;
            default:  result = rs_val | rt_val;
        endcase
        if (wr_en) begin
            model_regs[ins.rd] = result;
        end
        model_regs[0] = '0;                     // Writes to r0 are lost
    endfunction

    task automatic run_instr();
        instr_t ins;
        word_t  fetch_pc;
        int     cycles;
        int     strobes;
        logic   seen_fetch;
        ins      = random_instr();
        fetch_pc = model_pc;
        check_value("imem_addr", imem_addr, model_pc);
        imem_data = ins;                        // Held until the next fetch
        apply_model(ins);
        cycles     = 0;
        strobes    = 0;
        seen_fetch = 1'b0;
        while (!seen_fetch && cycles < FETCH_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            if (fetch) begin
                seen_fetch = 1'b1;
            end else if (dmem_re || dmem_we) begin
                strobes++;
                check_value("data strobe cycle", 16'(cycles), 16'(DATA_STROBE_CYCLE));
                check_value("dmem_re", 16'(dmem_re), 16'(exp_kind == KIND_LOAD));
                check_value("dmem_we", 16'(dmem_we), 16'(exp_kind == KIND_STORE));
                check_value("dmem_addr", dmem_addr, exp_addr);
                if (dmem_we) begin
                    check_value("dmem_wdata", dmem_wdata, exp_wdata);
                end
                if (dmem_re) begin
                    dmem_rdata = mem_read(dmem_addr);   // Captured at the end of this cycle
                end
            end
        end
        if (!seen_fetch) begin
            timeout_count++;
            $display("Timeout: no fetch strobe within %0d cycles after the fetch at %h",
                     FETCH_TIMEOUT, fetch_pc);
        end else begin
            check_value("fetch gap", 16'(cycles), 16'(exp_gap));
            check_value("data strobe count", 16'(strobes), 16'(exp_kind != KIND_NONE));
        end
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        rst_ABC       = 1'b1;
        imem_data     = '0;
        dmem_rdata    = '0;
        error_count   = 0;
        check_count   = 0;
        timeout_count = 0;
        model_pc      = '0;
        model_regs    = '{default: '0};
        repeat (10) begin
            @(posedge clk);
            #1;
            check_value("dmem_re", 16'(dmem_re), 16'h0);
            check_value("dmem_we", 16'(dmem_we), 16'h0);
        end
        rst_ABC = 1'b0;
        check_value("fetch", 16'(fetch), 16'h1);
        for (int n = 0; n < NUM_INSTR && timeout_count == 0; n++) begin
            run_instr();
        end
        $display("Checks: %0d, value errors: %0d, timeouts: %0d, assertion failures: %0d",
                 check_count, error_count, timeout_count, UUT.u_checker.fail_count);
        if (error_count == 0 && timeout_count == 0 && UUT.u_checker.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
